//--- hdl/cache_geom_pkg.sv
// cache geometry: address, word, line, tag and index widths with their vector types
`default_nettype none

package cache_geom_pkg;

	// ------------------------------------------------------------------------
	// basic sizes
	// ------------------------------------------------------------------------
	localparam int word_addr_bits = 30;  // processor addresses words, not bytes
	localparam int word_bits      = 32;
	localparam int num_sets       = 4;
	localparam int words_per_line = 4;

	// derived field widths
	localparam int off_bits       = $clog2(words_per_line);
	localparam int idx_bits       = $clog2(num_sets);
	localparam int tag_bits       = word_addr_bits - idx_bits - off_bits;
	localparam int line_addr_bits = word_addr_bits - off_bits;
	localparam int line_bits      = words_per_line * word_bits;

	// ------------------------------------------------------------------------
	// vector types
	// ------------------------------------------------------------------------
	typedef logic [word_addr_bits-1:0] word_addr_t;  // proc side address
	typedef logic [line_addr_bits-1:0] line_addr_t;  // mem side address, one per line
	typedef logic [word_bits-1:0]      word_t;
	typedef logic [line_bits-1:0]      line_t;       // word 0 in the low bits

	// word address split: {tag, set index, word offset}
	typedef logic [tag_bits-1:0]       tag_t;        // bits 29:4
	typedef logic [idx_bits-1:0]       set_idx_t;    // bits 3:2
	typedef logic [off_bits-1:0]       word_off_t;   // bits 1:0

endpackage

`default_nettype wire

//--- hdl/cache_ctrl_pkg.sv
// controller state encoding and way-select type for the data cache
`default_nettype none

package cache_ctrl_pkg;

	localparam int num_ways = 2;

	// miss handling FSM
	typedef enum logic [1:0] {
		idle,         // one cycle after reset
		compare_tag,  // normal operation, hits served here
		write_back,   // dirty victim goes out first
		allocate      // refill from memory
	} cache_state_t;

	// names one of the ways, also used as the per-set replacement bit
	typedef logic [$clog2(num_ways)-1:0] way_sel_t;

endpackage

`default_nettype wire

//--- hdl/way_if.sv
// interface between the cache controller and one cache way
`timescale 1ns/1ps
`default_nettype none

interface way_if;

	// controller to way
	cache_geom_pkg::set_idx_t  set_idx;
	cache_geom_pkg::word_off_t word_off;
	cache_geom_pkg::tag_t      tag;        // tag to compare, also stored on fill
	logic                      fill_en;
	cache_geom_pkg::line_t     fill_line;
	logic                      write_en;
	cache_geom_pkg::word_t     write_word;
	logic                      clean_en;

	// way to controller, all for the addressed set
	logic                      hit;
	cache_geom_pkg::word_t     hit_word;
	cache_geom_pkg::tag_t      victim_tag;
	cache_geom_pkg::line_t     victim_line;
	logic                      dirty;

	modport way (
		input  set_idx, word_off, tag, fill_en, fill_line,
		input  write_en, write_word, clean_en,
		output hit, hit_word, victim_tag, victim_line, dirty
	);

	modport ctrl (
		output set_idx, word_off, tag, fill_en, fill_line,
		output write_en, write_word, clean_en,
		input  hit, hit_word, victim_tag, victim_line, dirty
	);

endinterface

`default_nettype wire

//--- hdl/cache_way.sv
// one cache way: tag, data, valid and dirty storage with hit check and update
`timescale 1ns/1ps
`default_nettype none

module cache_way (
	input  logic clk,
	input  logic proc_reset,
	way_if.way   port
);

	// ------------------------------------------------------------------------
	// storage, one entry per set
	// ------------------------------------------------------------------------
	logic [cache_geom_pkg::num_sets-1:0] valid_q;
	logic [cache_geom_pkg::num_sets-1:0] dirty_q;
	cache_geom_pkg::tag_t                tag_q  [cache_geom_pkg::num_sets];
	cache_geom_pkg::line_t               line_q [cache_geom_pkg::num_sets];

	cache_geom_pkg::line_t               cur_line;

	// ------------------------------------------------------------------------
	// read side, purely combinational
	// ------------------------------------------------------------------------
	assign cur_line = line_q[port.set_idx];

	assign port.hit = valid_q[port.set_idx] && (tag_q[port.set_idx] == port.tag);

	// select the requested word out of the line
	assign port.hit_word =
		cur_line[port.word_off*cache_geom_pkg::word_bits +: cache_geom_pkg::word_bits];

	// what would go out to memory if this way is evicted
	assign port.victim_tag  = tag_q[port.set_idx];
	assign port.victim_line = cur_line;
	assign port.dirty       = dirty_q[port.set_idx];  // only ever set on a valid line

	// ------------------------------------------------------------------------
	// flags
	// ------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (proc_reset) begin
			valid_q <= '0;  // every line invalid and clean
			dirty_q <= '0;
		end else if (port.fill_en) begin
			valid_q[port.set_idx] <= 1'b1;
			dirty_q[port.set_idx] <= 1'b0;  // fresh copy of memory
		end else if (port.write_en) begin
			dirty_q[port.set_idx] <= 1'b1;
		end else if (port.clean_en) begin
			dirty_q[port.set_idx] <= 1'b0;  // write-back done
		end
	end

	// ------------------------------------------------------------------------
	// tag and data
	// ------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (port.fill_en) begin
			tag_q[port.set_idx]  <= port.tag;
			line_q[port.set_idx] <= port.fill_line;
		end else if (port.write_en) begin
			// single word store into a resident line
			line_q[port.set_idx][port.word_off*cache_geom_pkg::word_bits
				+: cache_geom_pkg::word_bits] <= port.write_word;
		end
	end

endmodule

`default_nettype wire

//--- hdl/cache_controller.sv
// data cache controller: hit combining, replacement bits, miss FSM and memory requests
`timescale 1ns/1ps
`default_nettype none

module cache_controller (
	input  logic                       clk,
	input  logic                       proc_reset,
	// processor side
	input  logic                       proc_read,
	input  logic                       proc_write,
	input  cache_geom_pkg::word_addr_t proc_addr,
	input  cache_geom_pkg::word_t      proc_wdata,
	output cache_geom_pkg::word_t      proc_rdata,
	output logic                       proc_stall,
	// memory side
	output logic                       mem_read,
	output logic                       mem_write,
	output cache_geom_pkg::line_addr_t mem_addr,
	output cache_geom_pkg::line_t      mem_wdata,
	input  cache_geom_pkg::line_t      mem_rdata,
	input  logic                       mem_ready,
	// the two ways
	way_if.ctrl                        way0,
	way_if.ctrl                        way1
);

	cache_geom_pkg::tag_t      addr_tag;
	cache_geom_pkg::set_idx_t  addr_set;
	cache_geom_pkg::word_off_t addr_off;

	cache_ctrl_pkg::cache_state_t state_q;
	cache_ctrl_pkg::cache_state_t state_d;

	cache_ctrl_pkg::way_sel_t [cache_geom_pkg::num_sets-1:0] repl_q;  // next way to replace
	cache_ctrl_pkg::way_sel_t victim;

	logic                  access;
	logic                  miss;
	logic                  victim_dirty;
	cache_geom_pkg::tag_t  victim_tag;
	cache_geom_pkg::line_t victim_line;

	// strobes from the FSM, then steered to one way
	logic fill_now;
	logic write_now;
	logic clean_now;
	logic [cache_ctrl_pkg::num_ways-1:0] fill_sel;
	logic [cache_ctrl_pkg::num_ways-1:0] write_sel;
	logic [cache_ctrl_pkg::num_ways-1:0] clean_sel;
	logic [cache_ctrl_pkg::num_ways-1:0] victim_oh;

	// ------------------------------------------------------------------------
	// address split and way drive
	// ------------------------------------------------------------------------
	assign {addr_tag, addr_set, addr_off} = proc_addr;

	assign way0.set_idx    = addr_set;
	assign way0.word_off   = addr_off;
	assign way0.tag        = addr_tag;
	assign way0.fill_line  = mem_rdata;
	assign way0.write_word = proc_wdata;
	assign way1.set_idx    = addr_set;
	assign way1.word_off   = addr_off;
	assign way1.tag        = addr_tag;
	assign way1.fill_line  = mem_rdata;
	assign way1.write_word = proc_wdata;

	// ------------------------------------------------------------------------
	// hit combining, way 0 wins
	// ------------------------------------------------------------------------
	assign access     = proc_read | proc_write;
	assign miss       = access & ~way0.hit & ~way1.hit;
	assign proc_rdata = way0.hit ? way0.hit_word : way1.hit_word;

	// victim of the addressed set
	assign victim       = repl_q[addr_set];
	assign victim_oh    = {victim[0], ~victim[0]};
	assign victim_dirty = victim[0] ? way1.dirty       : way0.dirty;
	assign victim_tag   = victim[0] ? way1.victim_tag  : way0.victim_tag;
	assign victim_line  = victim[0] ? way1.victim_line : way0.victim_line;

	assign mem_wdata = victim_line;  // only looked at during write_back

	// ------------------------------------------------------------------------
	// miss FSM
	// ------------------------------------------------------------------------
	always_comb begin
		state_d    = state_q;
		proc_stall = 1'b1;
		mem_read   = 1'b0;
		mem_write  = 1'b0;
		mem_addr   = {addr_tag, addr_set};  // refill address
		fill_now   = 1'b0;
		write_now  = 1'b0;
		clean_now  = 1'b0;
		unique case (state_q)
			cache_ctrl_pkg::idle: begin
				state_d = cache_ctrl_pkg::compare_tag;
			end
			cache_ctrl_pkg::compare_tag: begin
				proc_stall = miss;
				write_now  = proc_write & ~miss;  // store hit
				if (miss) begin
					state_d = victim_dirty ? cache_ctrl_pkg::write_back
					                       : cache_ctrl_pkg::allocate;
				end
			end
			cache_ctrl_pkg::write_back: begin
				mem_addr  = {victim_tag, addr_set};  // where the victim came from
				mem_write = ~mem_ready;               // drops as soon as ready shows
				if (mem_ready) begin
					clean_now = 1'b1;
					state_d   = cache_ctrl_pkg::allocate;
				end
			end
			cache_ctrl_pkg::allocate: begin
				mem_read = ~mem_ready;
				if (mem_ready) begin
					fill_now = 1'b1;
					state_d  = cache_ctrl_pkg::compare_tag;  // access hits there
				end
			end
			default: begin
				state_d = cache_ctrl_pkg::idle;
			end
		endcase
	end

	// steer the strobes
	assign fill_sel  = fill_now  ? victim_oh : '0;
	assign clean_sel = clean_now ? victim_oh : '0;
	assign write_sel = {way1.hit & ~way0.hit, way0.hit} & {cache_ctrl_pkg::num_ways{write_now}};

	assign way0.fill_en  = fill_sel[0];
	assign way1.fill_en  = fill_sel[1];
	assign way0.write_en = write_sel[0];
	assign way1.write_en = write_sel[1];
	assign way0.clean_en = clean_sel[0];
	assign way1.clean_en = clean_sel[1];

	// ------------------------------------------------------------------------
	// state and replacement bits
	// ------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (proc_reset) begin
			state_q <= cache_ctrl_pkg::idle;
			repl_q  <= '0;  // all sets replace way 0 first
		end else begin
			state_q <= state_d;
			if (fill_now) begin
				repl_q[addr_set] <= ~victim;  // other way goes next
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/dcache_top.sv
// data cache top level: plain processor and memory ports, two ways and the controller
`timescale 1ns/1ps
`default_nettype none

module dcache_top (
	input  logic                       clk,
	input  logic                       proc_reset,
	// processor side
	input  logic                       proc_read,
	input  logic                       proc_write,
	input  cache_geom_pkg::word_addr_t proc_addr,
	input  cache_geom_pkg::word_t      proc_wdata,
	output cache_geom_pkg::word_t      proc_rdata,
	output logic                       proc_stall,
	// memory side
	output logic                       mem_read,
	output logic                       mem_write,
	output cache_geom_pkg::line_addr_t mem_addr,
	output cache_geom_pkg::line_t      mem_wdata,
	input  cache_geom_pkg::line_t      mem_rdata,
	input  logic                       mem_ready
);

	// ------------------------------------------------------------------------
	// one bus per way
	// ------------------------------------------------------------------------
	way_if way0_bus ();
	way_if way1_bus ();

	cache_way way0_i (
		.clk        (clk),
		.proc_reset (proc_reset),
		.port       (way0_bus.way)
	);

	cache_way way1_i (
		.clk        (clk),
		.proc_reset (proc_reset),
		.port       (way1_bus.way)
	);

	// ------------------------------------------------------------------------
	// controller
	// ------------------------------------------------------------------------
	cache_controller ctrl_i (
		.clk        (clk),
		.proc_reset (proc_reset),
		.proc_read  (proc_read),
		.proc_write (proc_write),
		.proc_addr  (proc_addr),
		.proc_wdata (proc_wdata),
		.proc_rdata (proc_rdata),
		.proc_stall (proc_stall),
		.mem_read   (mem_read),
		.mem_write  (mem_write),
		.mem_addr   (mem_addr),
		.mem_wdata  (mem_wdata),
		.mem_rdata  (mem_rdata),
		.mem_ready  (mem_ready),
		.way0       (way0_bus.ctrl),
		.way1       (way1_bus.ctrl)
	);

endmodule

`default_nettype wire

//--- bench/slow_mem_model.sv
// line-wide memory model with random latency, a one-cycle ready pulse and traffic counters
`timescale 1ns/1ps
`default_nettype none

module slow_mem_model #(
	parameter int unsigned seed = 1
) (
	input  logic                       clk,
	input  logic                       mem_read,
	input  logic                       mem_write,
	input  cache_geom_pkg::line_addr_t mem_addr,
	input  cache_geom_pkg::line_t      mem_wdata,
	output cache_geom_pkg::line_t      mem_rdata,
	output logic                       mem_ready,
	output int unsigned                read_count,
	output int unsigned                write_count,
	output cache_geom_pkg::line_addr_t last_write_addr,
	output cache_geom_pkg::line_t      last_write_line,
	output int unsigned                protocol_errors
);

	cache_geom_pkg::line_t      lines [cache_geom_pkg::line_addr_t];  // written lines only
	logic                       busy;
	int unsigned                wait_cnt;
	logic                       req_is_write;
	cache_geom_pkg::line_addr_t req_addr;
	cache_geom_pkg::line_t      req_line;

	// untouched memory: each word is its word address xor 32'h5a5a0000
	function automatic cache_geom_pkg::line_t read_line(input cache_geom_pkg::line_addr_t addr);
		cache_geom_pkg::line_t      line;
		cache_geom_pkg::word_addr_t waddr;
		if (lines.exists(addr)) begin
			return lines[addr];
		end
		line = '0;
		for (int w = 0; w < cache_geom_pkg::words_per_line; w++) begin
			waddr = {addr, cache_geom_pkg::word_off_t'(w)};
			line[w*cache_geom_pkg::word_bits +: cache_geom_pkg::word_bits] =
				{2'b00, waddr} ^ 32'h5a5a0000;
		end
		return line;
	endfunction

	// ------------------------------------------------------------------------
	// request handling, one request at a time
	// ------------------------------------------------------------------------
	initial begin
		void'($urandom(seed));
		busy            = 1'b0;
		wait_cnt        = 0;
		mem_ready       <= 1'b0;
		mem_rdata       <= '0;
		read_count      <= 0;
		write_count     <= 0;
		last_write_addr <= '0;
		last_write_line <= '0;
		protocol_errors <= 0;
		forever begin
			@(posedge clk);
			if (mem_ready) begin
				mem_ready <= 1'b0;  // single cycle pulse
			end else if (busy) begin
				// request must hold steady until ready
				if ((req_is_write ? !mem_write : !mem_read) || mem_addr != req_addr) begin
					$display("memory request dropped or moved before mem_ready at %0t", $time);
					protocol_errors <= protocol_errors + 1;
				end
				if (req_is_write && mem_wdata !== req_line) begin
					$display("write data changed before mem_ready at %0t", $time);
					protocol_errors <= protocol_errors + 1;
				end
				wait_cnt = wait_cnt - 1;
				if (wait_cnt == 0) begin
					busy      = 1'b0;
					mem_ready <= 1'b1;
					if (req_is_write) begin
						lines[req_addr] = req_line;
						write_count     <= write_count + 1;
						last_write_addr <= req_addr;
						last_write_line <= req_line;
					end else begin
						mem_rdata  <= read_line(req_addr);
						read_count <= read_count + 1;
					end
				end
			end else if (mem_read || mem_write) begin
				if (mem_read && mem_write) begin
					$display("mem_read and mem_write both high at %0t", $time);
					protocol_errors <= protocol_errors + 1;
				end
				busy         = 1'b1;
				req_is_write = mem_write;
				req_addr     = mem_addr;
				req_line     = mem_wdata;
				wait_cnt     = 2 + ($urandom % 5);  // 2 to 6 cycles
			end
		end
	end

endmodule

`default_nettype wire

//--- bench/tb_dcache.sv
// data cache testbench: clock, reset, file-driven accesses, compare tasks, watchdog, summary
`timescale 1ns/1ps
`default_nettype none

module tb_dcache;

	localparam int half_period     = 50;
	localparam int settle_time     = 25;  // inputs settled, next rising edge still ahead
	localparam int fields          = 5;
	localparam int max_lines       = 64;
	localparam int cycles_per_line = 40;
	localparam int op_read         = 0;
	localparam int op_write        = 1;
	localparam int op_wb_check     = 2;   // compares the last write-back

	logic                       clk;
	logic                       proc_reset;
	logic                       proc_read;
	logic                       proc_write;
	cache_geom_pkg::word_addr_t proc_addr;
	cache_geom_pkg::word_t      proc_wdata;
	cache_geom_pkg::word_t      proc_rdata;
	logic                       proc_stall;
	logic                       mem_read;
	logic                       mem_write;
	cache_geom_pkg::line_addr_t mem_addr;
	cache_geom_pkg::line_t      mem_wdata;
	cache_geom_pkg::line_t      mem_rdata;
	logic                       mem_ready;

	int unsigned                mem_read_count;
	int unsigned                mem_write_count;
	int unsigned                mem_protocol_errors;
	cache_geom_pkg::line_addr_t last_wb_addr;
	cache_geom_pkg::line_t      last_wb_line;

	logic [31:0] stim_mem [max_lines*fields];
	int          num_lines;
	int          limit_cycles = 0;
	int          check_count = 0;
	int          mismatch_count = 0;
	int          other_errors = 0;
	int unsigned checked_writes = 0;

	dcache_top dut_i (
		.clk        (clk),
		.proc_reset (proc_reset),
		.proc_read  (proc_read),
		.proc_write (proc_write),
		.proc_addr  (proc_addr),
		.proc_wdata (proc_wdata),
		.proc_rdata (proc_rdata),
		.proc_stall (proc_stall),
		.mem_read   (mem_read),
		.mem_write  (mem_write),
		.mem_addr   (mem_addr),
		.mem_wdata  (mem_wdata),
		.mem_rdata  (mem_rdata),
		.mem_ready  (mem_ready)
	);

	slow_mem_model #(.seed(32'he875b5e3)) mem_i (
		.clk             (clk),
		.mem_read        (mem_read),
		.mem_write       (mem_write),
		.mem_addr        (mem_addr),
		.mem_wdata       (mem_wdata),
		.mem_rdata       (mem_rdata),
		.mem_ready       (mem_ready),
		.read_count      (mem_read_count),
		.write_count     (mem_write_count),
		.last_write_addr (last_wb_addr),
		.last_write_line (last_wb_line),
		.protocol_errors (mem_protocol_errors)
	);

	initial begin
		clk = 1'b0;
		forever #half_period clk = ~clk;
	end

	// ------------------------------------------------------------------------
	// compare tasks
	// ------------------------------------------------------------------------
	task automatic check_word(input string name, input cache_geom_pkg::word_t expected,
		input cache_geom_pkg::word_t actual);
		check_count++;
		if (actual !== expected) begin
			mismatch_count++;
			$display("mismatch %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic check_line_addr(input string name, input cache_geom_pkg::line_addr_t expected,
		input cache_geom_pkg::line_addr_t actual);
		check_count++;
		if (actual !== expected) begin
			mismatch_count++;
			$display("mismatch %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic check_flag(input string name, input bit expected, input bit actual);
		check_count++;
		if (actual !== expected) begin
			mismatch_count++;
			$display("mismatch %s: expected %0b, actual %0b", name, expected, actual);
		end
	endtask

	task automatic print_summary();
		$display("checks: %0d, mismatches: %0d, other errors: %0d, memory protocol errors: %0d",
			check_count, mismatch_count, other_errors, mem_protocol_errors);
	endtask

	// ------------------------------------------------------------------------
	// access sequencing
	// ------------------------------------------------------------------------
	task automatic check_idle_bus(input int cycles);
		for (int c = 0; c < cycles; c++) begin
			@(negedge clk);
			#settle_time;
			if (mem_read || mem_write) begin
				other_errors++;
				$display("memory request raised with no access pending at %0t", $time);
			end
		end
	endtask

	task automatic run_access(input int idx, input logic [31:0] op, input logic [31:0] addr_raw,
		input logic [31:0] wdata, input logic [31:0] exp_data, input logic [31:0] exp_miss);
		bit          saw_stall;
		int unsigned reads_before;
		int unsigned writes_before;
		@(negedge clk);
		reads_before  = mem_read_count;
		writes_before = mem_write_count;
		proc_addr     = addr_raw[29:0];
		proc_wdata    = wdata;
		proc_read     = (op == op_read);
		proc_write    = (op == op_write);
		#settle_time;
		saw_stall = proc_stall;  // stall in the first cycle means a miss
		while (proc_stall) begin
			@(negedge clk);
			#settle_time;
		end
		check_flag($sformatf("line %0d miss flag", idx), exp_miss[0], saw_stall);
		if (op == op_read) begin
			check_word($sformatf("line %0d read data", idx), exp_data, proc_rdata);
		end
		if (exp_miss[0] && mem_read_count - reads_before != 1) begin
			other_errors++;
			$display("line %0d: miss made %0d memory reads instead of one", idx,
				mem_read_count - reads_before);
		end
		if (mem_write_count - writes_before > 1) begin
			other_errors++;
			$display("line %0d: more than one write-back during one access", idx);
		end
		if (!exp_miss[0] && (mem_read_count != reads_before || mem_write_count != writes_before)) begin
			other_errors++;
			$display("line %0d: hit caused memory traffic", idx);
		end
		@(negedge clk);
		proc_read  = 1'b0;
		proc_write = 1'b0;
	endtask

	// expects one write-back since the last such check
	task automatic verify_writeback(input int idx, input logic [31:0] addr_raw,
		input logic [31:0] exp_data);
		int off;
		off = addr_raw[1:0];
		if (mem_write_count != checked_writes + 1) begin
			other_errors++;
			$display("line %0d: expected exactly one write-back, saw %0d", idx,
				mem_write_count - checked_writes);
		end
		checked_writes = mem_write_count;
		check_line_addr($sformatf("line %0d write-back address", idx), addr_raw[29:2],
			last_wb_addr);
		check_word($sformatf("line %0d write-back data", idx), exp_data,
			last_wb_line[off*cache_geom_pkg::word_bits +: cache_geom_pkg::word_bits]);
	endtask

	// ------------------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------------------
	initial begin
		int          base;
		logic [31:0] op;
		proc_reset = 1'b1;
		proc_read  = 1'b0;
		proc_write = 1'b0;
		proc_addr  = '0;
		proc_wdata = '0;
		for (int i = 0; i < max_lines*fields; i++) begin
			stim_mem[i] = '1;  // all ones marks the end of the list
		end
		$readmemh("bench/dcache_stim.txt", stim_mem);
		num_lines = 0;
		while (num_lines < max_lines && stim_mem[num_lines*fields] != 32'hffffffff) begin
			num_lines++;
		end
		if (num_lines == 0) begin
			other_errors++;
			$display("stimulus file holds no accesses");
		end
		limit_cycles = num_lines * cycles_per_line + 20;  // plus reset and idle check

		repeat (2) @(posedge clk);
		@(negedge clk);
		proc_reset = 1'b0;
		check_idle_bus(4);

		for (int n = 0; n < num_lines; n++) begin
			base = n * fields;
			op   = stim_mem[base];
			if (op == op_wb_check) begin
				verify_writeback(n, stim_mem[base+1], stim_mem[base+3]);
			end else if (op == op_read || op == op_write) begin
				run_access(n, op, stim_mem[base+1], stim_mem[base+2], stim_mem[base+3],
					stim_mem[base+4]);
			end else begin
				other_errors++;
				$display("line %0d: unknown operation %h in stimulus file", n, op);
			end
		end

		if (mem_write_count != checked_writes) begin
			other_errors++;
			$display("write-back happened that no stimulus line expected");
		end
		print_summary();
		if (mismatch_count == 0 && other_errors == 0 && mem_protocol_errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

	// watchdog sized from the number of stimulus lines
	initial begin
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge clk);
		other_errors++;
		$display("timeout: run did not finish within %0d cycles", limit_cycles);
		print_summary();
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- dcache.f
hdl/cache_geom_pkg.sv
hdl/cache_ctrl_pkg.sv
hdl/way_if.sv
hdl/cache_way.sv
hdl/cache_controller.sv
hdl/dcache_top.sv
bench/slow_mem_model.sv
bench/tb_dcache.sv

//--- run_sim.sh
#!/bin/sh
# build the data cache testbench with Verilator, run it, judge the log

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --timescale 1ns/1ps \
	-f dcache.f --top-module tb_dcache -Mdir "$build_dir"
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$build_dir/Vtb_dcache" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -q "SOME TESTS FAILED" "$log_file"; then
	exit 1
fi
if ! grep -q "ALL TESTS PASSED" "$log_file"; then
	echo "simulation log holds no result line"
	exit 1
fi
exit 0

//--- bench/dcache_stim.txt
// columns: op (0 read, 1 write, 2 check last write-back), word address, write data,
// expected data (read word, or written-back word for op 2), expected miss flag
00000000 00000010 00000000 5a5a0010 00000001
00000000 00000013 00000000 5a5a0013 00000000
00000000 00000011 00000000 5a5a0011 00000000
00000001 00000012 cafe0012 00000000 00000000
00000000 00000012 00000000 cafe0012 00000000
00000000 00000110 00000000 5a5a0110 00000001
00000000 00000013 00000000 5a5a0013 00000000
00000000 00000111 00000000 5a5a0111 00000000
00000000 00000210 00000000 5a5a0210 00000001
00000002 00000012 00000000 cafe0012 00000000
00000000 00000111 00000000 5a5a0111 00000000
00000000 00000012 00000000 cafe0012 00000001
00000000 00000010 00000000 5a5a0010 00000000
00000000 00000110 00000000 5a5a0110 00000001
00000000 00000024 00000000 5a5a0024 00000001
00000001 00000025 beef0025 00000000 00000000
00000001 00000027 beef0027 00000000 00000000
00000000 00000025 00000000 beef0025 00000000
00000000 00000026 00000000 5a5a0026 00000000
00000000 00001024 00000000 5a5a1024 00000001
00000000 00002024 00000000 5a5a2024 00000001
00000002 00000025 00000000 beef0025 00000000
00000000 00000027 00000000 beef0027 00000001
00000000 00000025 00000000 beef0025 00000000
00000000 3ffffff8 00000000 65a5fff8 00000001
00000001 3ffffffb 12345678 00000000 00000000
00000000 3ffffffb 00000000 12345678 00000000
00000000 3ffffffa 00000000 65a5fffa 00000000
